/* sim.f */
source/core_pkg.sv
source/fetch_stage.sv
source/gpr_file.sv
source/instr_decoder.sv
source/decode_stage.sv
source/issue_stage.sv
source/execute_stage.sv
source/core_top.sv
sim/tb_core.sv

/* Makefile */
# Verilator build and run of the RV32I pipeline core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ps
TOP       := tb_core
FILELIST  := sim.f
OBJ_DIR   := obj_dir
PASS_MSG  := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only if the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_core.sv */
/*
 * Testbench for the RV32I pipeline core
 * Clock and reset, random instruction stream with gaps and halts,
 * reference model, retire checks and watchdog
 */

`default_nettype none

module tb_core;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          clk_period      = 40;
  localparam int          num_instr       = 400;
  localparam int          watchdog_cycles = num_instr * 4 + 200;
  localparam logic [31:0] reset_pc        = 32'h0000_1000;
  localparam logic [31:0] seed            = 32'hc1bb6ac0;
  // Opcodes the core does not handle
  localparam logic [6:0]  bad_opc [8] = '{7'b0000011, 7'b0100011, 7'b1100011, 7'b1101111,
                                          7'b1100111, 7'b1110011, 7'b0001111, 7'b0101111};

  logic              clock_in;
  logic              arst_n;
  logic              halt;
  logic              instr_valid;
  core_pkg::word_t   instr_data;
  logic              instr_ready;
  core_pkg::retire_t retire;

  logic [31:0]       mregs [32];  // Model register file
  logic [31:0]       model_pc;
  logic [31:0]       rng;
  core_pkg::retire_t exp_q [$];   // Expected retires in program order
  int                due_q [$];   // Cycle each retire is due
  int                value_errors;
  int                event_errors;
  int                checked;

  core_top #(.reset_pc(reset_pc)) u_dut (
    .clock_in, .arst_n, .halt, .instr_valid, .instr_data, .instr_ready, .retire
  );

  initial begin
    clock_in = 1'b0;
    forever #(clk_period / 2) clock_in = ~clock_in;
  end

  // --------------------------------------------------------------------------
  // Random numbers and instruction generation
  // --------------------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [31:0] gen_instr();
    logic [31:0] r;
    logic [31:0] s;
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    r    = next_rand();
    s    = next_rand();
    kind = r[15:12];
    rd   = {2'b00, r[2:0]};  // x0..x7 only for dense dependencies
    rs1  = {2'b00, r[5:3]};
    rs2  = {2'b00, r[8:6]};
    f3   = r[11:9];
    imm  = s[11:0];
    if (kind <= 4'd5) begin  // Legal R-type
      return {(r[16] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
              rs2, rs1, f3, rd, 7'b0110011};
    end else if (kind <= 4'd10) begin  // Legal OP-IMM
      if (f3 == 3'd1) imm[11:5] = 7'h00;
      if (f3 == 3'd5) imm[11:5] = r[16] ? 7'h20 : 7'h00;
      return {imm, rs1, f3, rd, 7'b0010011};
    end else if (kind == 4'd11) begin
      return {s[31:12], rd, 7'b0110111};  // LUI
    end else if (kind == 4'd12) begin
      return {s[31:12], rd, 7'b0010111};  // AUIPC
    end else if (kind == 4'd13) begin
      return {s[31:7], bad_opc[r[18:16]]};
    end else if (kind == 4'd14) begin
      return {s[31:25], rs2, rs1, f3, rd, 7'b0110011};  // Random funct7
    end
    return {s[31:20], rs1, r[16] ? 3'd1 : 3'd5, rd, 7'b0010011};  // Shift with random upper bits
  endfunction

  // --------------------------------------------------------------------------
  // Reference model executing one instruction in program order
  // --------------------------------------------------------------------------
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) return $signed(a) >>> b[4:0];  // Arithmetic
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic model_exec(input logic [31:0] w, output core_pkg::retire_t e);
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        legal;
    f7    = w[31:25];
    f3    = w[14:12];
    a     = mregs[w[19:15]];
    b     = mregs[w[24:20]];
    legal = 1'b1;
    res   = 32'h0;
    case (w[6:0])
      7'b0110011: begin  // OP
        legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        res   = alu_ref(f3, f7[5], a, b);
      end
      7'b0010011: begin  // OP-IMM
        if (f3 == 3'd1) legal = (f7 == 7'h00);
        if (f3 == 3'd5) legal = (f7 == 7'h00) || (f7 == 7'h20);
        res = alu_ref(f3, f3 == 3'd5 && f7[5], a, {{20{w[31]}}, w[31:20]});
      end
      7'b0110111: res = {w[31:12], 12'h000};
      7'b0010111: res = model_pc + {w[31:12], 12'h000};
      default:    legal = 1'b0;
    endcase
    e.valid   = 1'b1;
    e.pc      = model_pc;
    e.rd      = w[11:7];
    e.result  = res;
    e.wr_en   = legal;
    e.illegal = !legal;
    if (legal && w[11:7] != 5'd0) mregs[w[11:7]] = res;  // x0 stays zero
    model_pc = model_pc + 32'd4;
  endtask

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      value_errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_event(input string msg);
    event_errors++;
    $display("Error: %s", msg);
  endtask

  task automatic check_outputs(input int cycle);
    core_pkg::retire_t e;
    int                due;
    logic              missed;
    check_field("instr_ready", 32'(instr_ready), 32'(!halt));
    if (retire.valid === 1'b1) begin
      assert (exp_q.size() != 0) else begin
        report_event($sformatf("extra retire of pc %h at cycle %0d", retire.pc, cycle));
      end
      if (exp_q.size() != 0) begin
        e   = exp_q.pop_front();
        due = due_q.pop_front();
        checked++;
        assert (due == cycle) else begin
          report_event($sformatf("pc %h retired at cycle %0d, due at %0d", e.pc, cycle, due));
        end
        check_field("retire.pc", retire.pc, e.pc);
        check_field("retire.rd", 32'(retire.rd), 32'(e.rd));
        check_field("retire.wr_en", 32'(retire.wr_en), 32'(e.wr_en));
        check_field("retire.illegal", 32'(retire.illegal), 32'(e.illegal));
        if (!e.illegal) check_field("retire.result", retire.result, e.result);
      end
    end else begin
      assert (retire.valid === 1'b0) else report_event("retire.valid is unknown");
      missed = (due_q.size() != 0) && (due_q[0] <= cycle);
      assert (!missed) else begin
        report_event($sformatf("no retire at cycle %0d for pc %h", cycle, exp_q[0].pc));
      end
      if (missed) begin  // Drop it and keep going
        e   = exp_q.pop_front();
        due = due_q.pop_front();
      end
    end
  endtask

  task automatic print_summary();
    $display("Errors: %0d wrong values, %0d other, %0d of %0d retires checked",
             value_errors, event_errors, checked, num_instr);
  endtask

  // --------------------------------------------------------------------------
  // Stimulus driven on the falling edge
  // --------------------------------------------------------------------------
  initial begin : main
    core_pkg::retire_t e;
    int                cycle;
    int                issued;   // Instructions accepted so far
    int                halt_left;
    logic              hold;     // Offered word not yet taken
    logic [31:0]       cur_word;
    arst_n       = 1'b0;
    halt         = 1'b0;
    instr_valid  = 1'b0;
    instr_data   = '0;
    rng          = seed;
    model_pc     = reset_pc;
    value_errors = 0;
    event_errors = 0;
    checked      = 0;
    cycle        = 0;
    issued       = 0;
    halt_left    = 0;
    hold         = 1'b0;
    cur_word     = '0;
    for (int i = 0; i < 32; i++) mregs[i] = 32'h0;
    repeat (5) begin  // Nothing may retire during reset
      @(negedge clock_in);
      check_outputs(0);
    end
    arst_n = 1'b1;
    while (issued < num_instr || exp_q.size() != 0) begin
      @(negedge clock_in);
      cycle++;
      check_outputs(cycle);
      if (halt_left > 0) begin
        halt_left--;
      end else if (next_rand() % 16 == 0) begin
        halt_left = int'(next_rand() % 8) + 1;  // Halt burst of 1 to 8 cycles
      end
      halt = (halt_left > 0);
      if (!hold) begin
        if (issued < num_instr && next_rand() % 4 != 0) begin
          cur_word    = gen_instr();
          instr_valid = 1'b1;
          hold        = 1'b1;
        end else begin
          instr_valid = 1'b0;
          cur_word    = next_rand();  // Junk while idle
        end
        instr_data = cur_word;
      end
      if (instr_valid && !halt) begin  // Taken on the next rising edge
        model_exec(cur_word, e);
        exp_q.push_back(e);
        due_q.push_back(cycle + 4);
        issued++;
        hold = 1'b0;
      end
    end
    instr_valid = 1'b0;
    repeat (6) begin  // Nothing more may retire
      @(negedge clock_in);
      cycle++;
      check_outputs(cycle);
    end
    print_summary();
    if (value_errors + event_errors == 0 && checked == num_instr) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdog_cycles * clk_period);
    $display("Timeout after %0d cycles with %0d retires outstanding",
             watchdog_cycles, exp_q.size());
    print_summary();
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

/* source/core_top.sv */
/*
 * RV32I in-order pipeline core top level
 * IF, ID, IS, EX stages, register file and writeback bus
 */

`default_nettype none

module core_top #(
  parameter core_pkg::word_t reset_pc = 32'h0000_0000
) (
  input  wire logic            clock_in,
  input  wire logic            arst_n,
  input  wire logic            halt,
  input  wire logic            instr_valid,
  input  wire core_pkg::word_t instr_data,
  output logic                 instr_ready,
  output core_pkg::retire_t    retire      // Also the writeback bus
);

  // --------------------------------------------------------------------------
  // Pipeline registers and register file ports
  // --------------------------------------------------------------------------
  core_pkg::if_id_t    if_id;
  core_pkg::id_is_t    id_is;
  core_pkg::is_ex_t    is_ex;
  core_pkg::reg_addr_t rs1_addr, rs2_addr;
  core_pkg::word_t     rs1_data, rs2_data;
  core_pkg::reg_addr_t ex_rd;  // rd held in IS/EX
  logic                ex_wr;

  fetch_stage #(.reset_pc(reset_pc)) u_fetch (
    .clock_in, .arst_n, .halt, .instr_valid, .instr_data, .instr_ready,
    .if_id (if_id)
  );

  gpr_file u_gpr (
    .clock_in, .arst_n, .rs1_addr, .rs2_addr,
    .rd_addr  (retire.rd),
    .rd_wr    (retire.valid & retire.wr_en),  // Written at the end of WB
    .rd_data  (retire.result),
    .rs1_data, .rs2_data
  );

  decode_stage u_decode (
    .clock_in, .arst_n, .if_id,
    .wb (retire),
    .ex_rd, .ex_wr, .rs1_data, .rs2_data, .rs1_addr, .rs2_addr, .id_is
  );

  issue_stage u_issue (
    .clock_in, .arst_n, .id_is,
    .wb (retire),
    .is_ex, .ex_rd, .ex_wr
  );

  execute_stage u_execute (
    .clock_in, .arst_n, .is_ex,
    .wb (retire)
  );

endmodule

`default_nettype wire

/* source/execute_stage.sv */
/*
 * Execute stage
 * EX forward, integer ALU and EX/WB register (retire and writeback bus)
 */

`default_nettype none

module execute_stage (
  input  wire logic             clock_in,
  input  wire logic             arst_n,
  input  wire core_pkg::is_ex_t is_ex,
  output core_pkg::retire_t     wb
);

  core_pkg::word_t a;
  core_pkg::word_t b;
  core_pkg::word_t result;
  logic [4:0]      shamt;

  // Producer from IS two cycles ago is on the bus now
  assign a     = is_ex.ex_fwd_a ? wb.result : is_ex.op_a;
  assign b     = is_ex.ex_fwd_b ? wb.result : is_ex.op_b;
  assign shamt = b[4:0];

  // --------------------------------------------------------------------------
  // Integer ALU
  // --------------------------------------------------------------------------
  always_comb begin
    case (is_ex.alu_op)
      core_pkg::alu_add:    result = a + b;
      core_pkg::alu_sub:    result = a - b;
      core_pkg::alu_sll:    result = a << shamt;
      core_pkg::alu_slt:    result = {31'd0, $signed(a) < $signed(b)};
      core_pkg::alu_sltu:   result = {31'd0, a < b};
      core_pkg::alu_xor:    result = a ^ b;
      core_pkg::alu_srl:    result = a >> shamt;
      core_pkg::alu_sra:    result = $unsigned($signed(a) >>> shamt);  // Keeps sign
      core_pkg::alu_or:     result = a | b;
      core_pkg::alu_and:    result = a & b;
      core_pkg::alu_pass_b: result = b;  // LUI
      default:              result = '0;
    endcase
  end

  // EX/WB register
  always_ff @(posedge clock_in or negedge arst_n) begin
    if (!arst_n) begin
      wb <= '0;
    end else begin
      wb.valid   <= is_ex.valid;
      wb.pc      <= is_ex.pc;
      wb.rd      <= is_ex.rd;
      wb.result  <= result;
      wb.wr_en   <= is_ex.wr_en;
      wb.illegal <= is_ex.illegal;
    end
  end

endmodule

`default_nettype wire

/* source/issue_stage.sv */
/*
 * Instruction issue stage
 * IS forward, PC / immediate operand select and IS/EX register
 */

`default_nettype none

module issue_stage (
  input  wire logic              clock_in,
  input  wire logic              arst_n,
  input  wire core_pkg::id_is_t  id_is,
  input  wire core_pkg::retire_t wb,
  output core_pkg::is_ex_t       is_ex,
  output core_pkg::reg_addr_t    ex_rd,
  output logic                   ex_wr
);

  core_pkg::word_t  rs1_val;
  core_pkg::word_t  rs2_val;
  core_pkg::is_ex_t is_ex_d;

  // Producer that sat in EX is now on the bus
  assign rs1_val = id_is.is_fwd_a ? wb.result : id_is.rs1_data;
  assign rs2_val = id_is.is_fwd_b ? wb.result : id_is.rs2_data;

  always_comb begin
    is_ex_d.valid    = id_is.valid;
    is_ex_d.pc       = id_is.pc;
    is_ex_d.rd       = id_is.rd;
    is_ex_d.alu_op   = id_is.dec.alu_op;
    is_ex_d.wr_en    = id_is.dec.wr_en;
    is_ex_d.illegal  = id_is.dec.illegal;
    is_ex_d.op_a     = id_is.dec.a_is_pc ? id_is.pc : rs1_val;
    is_ex_d.op_b     = id_is.dec.b_is_imm ? id_is.dec.imm : rs2_val;
    // PC or immediate must survive EX forwarding
    is_ex_d.ex_fwd_a = id_is.ex_fwd_a & ~id_is.dec.a_is_pc;
    is_ex_d.ex_fwd_b = id_is.ex_fwd_b & ~id_is.dec.b_is_imm;
  end

  always_ff @(posedge clock_in or negedge arst_n) begin
    if (!arst_n) begin
      is_ex <= '0;
    end else begin
      is_ex <= is_ex_d;
    end
  end

  // EX producer seen by decode
  assign ex_rd = is_ex.rd;
  assign ex_wr = is_ex.valid & is_ex.wr_en;

endmodule

`default_nettype wire

/* source/decode_stage.sv */
/*
 * Instruction decode stage
 * Forwarding selection, ID operand forward and ID/IS register
 */

`default_nettype none

module decode_stage (
  input  wire logic                clock_in,
  input  wire logic                arst_n,
  input  wire core_pkg::if_id_t    if_id,
  input  wire core_pkg::retire_t   wb,
  input  wire core_pkg::reg_addr_t ex_rd,     // rd in IS/EX
  input  wire logic                ex_wr,
  input  wire core_pkg::word_t     rs1_data,
  input  wire core_pkg::word_t     rs2_data,
  output core_pkg::reg_addr_t      rs1_addr,
  output core_pkg::reg_addr_t      rs2_addr,
  output core_pkg::id_is_t         id_is
);

  core_pkg::dec_t   dec;
  core_pkg::fwd_t   fwd;
  core_pkg::id_is_t id_is_d;
  logic             is_wr;  // Producer in IS writes
  logic             wb_wr;  // Producer on writeback bus writes

  // Source matches a writing producer, x0 never matches
  function automatic logic hit(input core_pkg::reg_addr_t src, input core_pkg::reg_addr_t dst,
                               input logic wr);
    return wr && (dst != '0) && (src == dst);
  endfunction

  instr_decoder u_dec (
    .instr (if_id.instr),
    .dec   (dec)
  );

  assign rs1_addr = if_id.instr.r.rs1;
  assign rs2_addr = if_id.instr.r.rs2;

  assign is_wr = id_is.valid & id_is.dec.wr_en;
  assign wb_wr = wb.valid & wb.wr_en;

  // --------------------------------------------------------------------------
  // Forwarding, nearest producer wins
  // --------------------------------------------------------------------------
  always_comb begin
    fwd.a_ex = hit(rs1_addr, id_is.rd, is_wr);                // IS now, WB in 2
    fwd.a_is = !fwd.a_ex && hit(rs1_addr, ex_rd, ex_wr);      // EX now, WB in 1
    fwd.a_id = !fwd.a_ex && !fwd.a_is && hit(rs1_addr, wb.rd, wb_wr);
    fwd.b_ex = hit(rs2_addr, id_is.rd, is_wr);
    fwd.b_is = !fwd.b_ex && hit(rs2_addr, ex_rd, ex_wr);
    fwd.b_id = !fwd.b_ex && !fwd.b_is && hit(rs2_addr, wb.rd, wb_wr);
  end

  // Next ID/IS content
  always_comb begin
    id_is_d.valid    = if_id.valid;
    id_is_d.pc       = if_id.pc;
    id_is_d.rd       = if_id.instr.r.rd;
    id_is_d.dec      = dec;
    id_is_d.rs1_data = fwd.a_id ? wb.result : rs1_data;  // GPR write lands next edge
    id_is_d.rs2_data = fwd.b_id ? wb.result : rs2_data;
    id_is_d.is_fwd_a = fwd.a_is;
    id_is_d.is_fwd_b = fwd.b_is;
    id_is_d.ex_fwd_a = fwd.a_ex;
    id_is_d.ex_fwd_b = fwd.b_ex;
  end

  always_ff @(posedge clock_in or negedge arst_n) begin
    if (!arst_n) begin
      id_is <= '0;
    end else begin
      id_is <= id_is_d;
    end
  end

endmodule

`default_nettype wire

/* source/instr_decoder.sv */
/*
 * RV32I instruction decoder
 * OP, OP-IMM, LUI and AUIPC to ALU op, operand selects and immediate
 */

`default_nettype none

module instr_decoder (
  input  wire core_pkg::instr_t instr,
  output core_pkg::dec_t        dec
);

  // funct3 to ALU op, alt picks sub / sra
  function automatic core_pkg::alu_op_t f3_op(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000:  return alt ? core_pkg::alu_sub : core_pkg::alu_add;
      3'b001:  return core_pkg::alu_sll;
      3'b010:  return core_pkg::alu_slt;
      3'b011:  return core_pkg::alu_sltu;
      3'b100:  return core_pkg::alu_xor;
      3'b101:  return alt ? core_pkg::alu_sra : core_pkg::alu_srl;
      3'b110:  return core_pkg::alu_or;
      default: return core_pkg::alu_and;
    endcase
  endfunction

  always_comb begin
    dec        = '0;
    dec.alu_op = core_pkg::alu_add;
    case (instr.r.opcode)
      core_pkg::opc_op: begin
        dec.wr_en  = 1'b1;
        dec.alu_op = f3_op(instr.r.funct3, instr.r.funct7[5]);
        if (instr.r.funct7 == 7'b0100000) begin
          // Only sub and sra have the alternate encoding
          dec.illegal = !(instr.r.funct3 == 3'b000 || instr.r.funct3 == 3'b101);
        end else if (instr.r.funct7 != 7'b0000000) begin
          dec.illegal = 1'b1;
        end
      end
      core_pkg::opc_op_imm: begin
        dec.wr_en    = 1'b1;
        dec.b_is_imm = 1'b1;
        dec.imm      = {{20{instr.i.imm[11]}}, instr.i.imm};  // Sign extend
        // No subi, alt only for shifts
        dec.alu_op   = f3_op(instr.i.funct3, instr.i.funct3 == 3'b101 && instr.i.imm[10]);
        if (instr.i.funct3 == 3'b001) begin
          dec.illegal = (instr.i.imm[11:5] != 7'b0000000);  // slli
        end else if (instr.i.funct3 == 3'b101) begin
          dec.illegal = !(instr.i.imm[11:5] == 7'b0000000 ||
                          instr.i.imm[11:5] == 7'b0100000);  // srli / srai
        end
      end
      core_pkg::opc_lui: begin
        dec.wr_en    = 1'b1;
        dec.b_is_imm = 1'b1;
        dec.alu_op   = core_pkg::alu_pass_b;
        dec.imm      = {instr.u.imm, 12'h000};
      end
      core_pkg::opc_auipc: begin
        dec.wr_en    = 1'b1;
        dec.a_is_pc  = 1'b1;  // PC + upper immediate
        dec.b_is_imm = 1'b1;
        dec.imm      = {instr.u.imm, 12'h000};
      end
      default: begin
        dec.illegal = 1'b1;  // Loads, stores, branches, jumps, system
      end
    endcase
    if (dec.illegal) begin
      dec.wr_en = 1'b0;  // Never writes the GPRs
    end
  end

endmodule

`default_nettype wire

/* source/gpr_file.sv */
/*
 * General purpose register file
 * 32 x 32, two asynchronous reads, one synchronous write, x0 tied to zero
 */

`default_nettype none

module gpr_file (
  input  wire logic                clock_in,
  input  wire logic                arst_n,
  input  wire core_pkg::reg_addr_t rs1_addr,
  input  wire core_pkg::reg_addr_t rs2_addr,
  input  wire core_pkg::reg_addr_t rd_addr,
  input  wire logic                rd_wr,
  input  wire core_pkg::word_t     rd_data,
  output core_pkg::word_t          rs1_data,
  output core_pkg::word_t          rs2_data
);

  core_pkg::word_t regs [1:31];  // x1..x31

  // Read ports, x0 reads zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clock_in or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_wr && rd_addr != '0) begin  // Writes to x0 dropped
      regs[rd_addr] <= rd_data;
    end
  end

endmodule

`default_nettype wire

/* source/fetch_stage.sv */
/*
 * Instruction fetch stage
 * Stream handshake, PC counter and IF/ID register
 */

`default_nettype none

module fetch_stage #(
  parameter core_pkg::word_t reset_pc = 32'h0000_0000
) (
  input  wire logic            clock_in,
  input  wire logic            arst_n,
  input  wire logic            halt,
  input  wire logic            instr_valid,
  input  wire core_pkg::word_t instr_data,
  output logic                 instr_ready,
  output core_pkg::if_id_t     if_id
);

  core_pkg::word_t pc_q;  // PC of next accepted instruction
  logic            accept;

  assign instr_ready = ~halt;                   // Halt stalls fetch
  assign accept      = instr_valid & instr_ready;

  // PC counter and IF/ID register
  always_ff @(posedge clock_in or negedge arst_n) begin
    if (!arst_n) begin
      pc_q  <= reset_pc;
      if_id <= '0;
    end else begin
      if_id.valid <= accept;  // Bubble when nothing taken
      if (accept) begin
        pc_q        <= pc_q + 32'd4;
        if_id.pc    <= pc_q;
        if_id.instr <= instr_data;
      end
    end
  end

endmodule

`default_nettype wire

/* source/core_pkg.sv */
/*
 * Shared definitions of the RV32I pipeline core
 * Widths, instruction formats and union, ALU ops, stage structs
 */

`default_nettype none

package core_pkg;

  // --------------------------------------------------------------------------
  // Widths and basic types
  // --------------------------------------------------------------------------
  localparam int xlen       = 32;  // Data and PC width
  localparam int reg_addr_w = 5;   // 32 GPRs

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // Major opcodes handled by the core
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,  // Register-register
    opc_op_imm = 7'b0010011,  // Register-immediate
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111
  } opcode_t;

  // --------------------------------------------------------------------------
  // Instruction formats
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;     // Sign extended in decode
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0] imm;     // Upper 20 bits
    reg_addr_t   rd;
    opcode_t     opcode;
  } u_fmt_t;

  // Same word, three views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    u_fmt_t u;
  } instr_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and,
    alu_pass_b  // LUI
  } alu_op_t;

  // --------------------------------------------------------------------------
  // Decode and pipeline structs
  // --------------------------------------------------------------------------
  typedef struct packed {
    alu_op_t alu_op;
    logic    a_is_pc;   // A <= PC
    logic    b_is_imm;  // B <= immediate
    logic    wr_en;
    logic    illegal;
    word_t   imm;
  } dec_t;

  // Where the writeback bus replaces an operand
  typedef struct packed {
    logic a_id, a_is, a_ex;
    logic b_id, b_is, b_ex;
  } fwd_t;

  typedef struct packed {
    logic   valid;
    word_t  pc;
    instr_t instr;
  } if_id_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t rd;
    dec_t      dec;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      is_fwd_a, is_fwd_b;  // Applied in IS
    logic      ex_fwd_a, ex_fwd_b;  // Applied in EX
  } id_is_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t rd;
    alu_op_t   alu_op;
    logic      wr_en;
    logic      illegal;
    word_t     op_a;
    word_t     op_b;
    logic      ex_fwd_a, ex_fwd_b;  // Already masked
  } is_ex_t;

  // Retire port and writeback bus
  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t rd;
    word_t     result;
    logic      wr_en;
    logic      illegal;
  } retire_t;

endpackage

`default_nettype wire
